/* verilog/axis_pkg.sv */
// **************************************************************************
// Stream beat formats shared by the interconnect and its testbench.
// axis_beat_t is sized for DATA_W_DEF only. Other widths build their own
// struct with the same field order {tkeep, tuser, tlast, tdata}.
// **************************************************************************
`default_nettype none

package axis_pkg;

    localparam int DATA_W_DEF = 32;                 // Default tdata width in bits

    // tkeep carries one bit per byte, never less than one bit
    function automatic int keep_w(input int data_w);
        return (data_w / 8 > 0) ? data_w / 8 : 1;
    endfunction

    localparam int KEEP_W_DEF = keep_w(DATA_W_DEF); // Byte enables at default width

    // Field order matches the packed payload on the arbiter path
    typedef struct packed {
        logic [KEEP_W_DEF-1:0] tkeep;               // Byte qualifiers
        logic                  tuser;               // Frame end marker with tlast
        logic                  tlast;               // Sub-frame end
        logic [DATA_W_DEF-1:0] tdata;               // Payload word
    } axis_beat_t;

endpackage

`default_nettype wire

/* verilog/arb_pkg.sv */
// **************************************************************************
// Arbitration policy and index sizing for the many-to-one interconnect.
// Only round robin and fixed priority are provided.
// **************************************************************************
`default_nettype none

package arb_pkg;

    // Grant policy selected per instance
    typedef enum logic {
        ARB_ROUND_ROBIN = 1'b0,                     // Search starts after last owner
        ARB_FIXED       = 1'b1                      // Lowest requesting index wins
    } arb_policy_e;

    // Width of a source index, at least one bit even for a single source
    function automatic int idx_w(input int num);
        int w;
        w = 1;
        while ((1 << w) < num) begin
            w++;                                    // Grow until 2**w covers num
        end
        return w;
    endfunction

endpackage

`default_nettype wire

/* verilog/axis_if.sv */
// **************************************************************************
// AXI-Stream bundle without tid/tdest. The clock and reset are carried
// as module ports, not by this interface. tkeep width follows keep_w.
// **************************************************************************
`timescale 1ns/1ps
`default_nettype none

interface axis_if
    import axis_pkg::*;
#(
    parameter int DATA_W = DATA_W_DEF               // tdata width in bits
);

    localparam int KEEP_W = keep_w(DATA_W);         // One qualifier per byte

    logic [DATA_W-1:0] tdata;                       // Payload word
    logic [KEEP_W-1:0] tkeep;                       // Byte qualifiers
    logic              tlast;                       // Sub-frame end
    logic              tuser;                       // Frame end when set with tlast
    logic              tvalid;                      // Beat offered
    logic              tready;                      // Beat taken

    // Upstream side drives the beat
    modport master (
        output tdata, tkeep, tlast, tuser, tvalid,
        input  tready
    );

    // Downstream side returns ready
    modport slave (
        input  tdata, tkeep, tlast, tuser, tvalid,
        output tready
    );

endinterface

`default_nettype wire

/* verilog/data_if.sv */
// **************************************************************************
// Generic valid/ready channel. A beat moves on a clock edge with valid
// and ready both high. data must hold while valid waits for ready.
// **************************************************************************
`timescale 1ns/1ps
`default_nettype none

interface data_if #(
    parameter type payload_t = logic [31:0]         // Beat format carried
);

    payload_t data;                                 // Beat contents
    logic     valid;                                // Beat offered
    logic     ready;                                // Beat taken

    // Producer side
    modport master (
        output data, valid,
        input  ready
    );

    // Consumer side
    modport slave (
        input  data, valid,
        output ready
    );

endinterface

`default_nettype wire

/* verilog/data_skid_pipe.sv */
// **************************************************************************
// Two-entry registered skid buffer. Latency is one cycle when not stalled.
// Input ready is a flop, so downstream ready never reaches upstream logic.
// Input ready is low during reset and on the first cycle after it.
// **************************************************************************
`timescale 1ns/1ps
`default_nettype none

module data_skid_pipe #(
    parameter type payload_t = logic [31:0]         // Beat format
)(
    input  wire     aclk,
    input  wire     rst,
    data_if.slave   s,                              // Upstream channel
    data_if.master  m                               // Downstream channel
);

    payload_t main_data;                            // Output register
    payload_t skid_data;                            // Overflow register
    logic     main_valid;                           // Output register holds a beat
    logic     skid_valid;                           // Overflow register holds a beat
    logic     in_rdy;                               // Registered upstream ready

    logic     s_xfer;                               // Beat accepted this edge
    logic     main_free;                            // Output slot empty or leaving
    logic     main_v_nxt;
    logic     skid_v_nxt;

    assign s_xfer    = s.valid && in_rdy;
    assign main_free = !main_valid || m.ready;

    // Next occupancy of both slots
    always_comb begin
        if (main_free) begin
            main_v_nxt = skid_valid || s_xfer;      // Skid moves up, else input lands
            skid_v_nxt = skid_valid && s_xfer;      // Refill skid behind it
        end else begin
            main_v_nxt = main_valid;                // Stalled, output holds
            skid_v_nxt = skid_valid || s_xfer;      // Overflow catches input
        end
    end

    // **********************************************************************
    // Control flags
    // **********************************************************************
    always_ff @(posedge aclk) begin
        if (rst) begin
            main_valid <= 1'b0;
            skid_valid <= 1'b0;
            in_rdy     <= 1'b0;                     // Hold upstream off in reset
        end else begin
            main_valid <= main_v_nxt;
            skid_valid <= skid_v_nxt;
            in_rdy     <= !(main_v_nxt && skid_v_nxt); // Room for one more beat
        end
    end

    // Payload path, no reset needed
    always_ff @(posedge aclk) begin
        if (main_free && skid_valid) begin
            main_data <= skid_data;                 // Oldest beat first
        end else if (main_free && s_xfer) begin
            main_data <= s.data;                    // Straight through
        end
        if (s_xfer && (skid_valid || !main_free)) begin
            skid_data <= s.data;                    // Park behind output
        end
    end

    assign s.ready = in_rdy;
    assign m.valid = main_valid;
    assign m.data  = main_data;

    // Skid slot only fills behind a held output beat
    a_skid_order: assert property (@(posedge aclk) disable iff (rst)
        skid_valid |-> main_valid);

endmodule

`default_nettype wire

/* verilog/data_m2s_arbiter.sv */
// **************************************************************************
// NUM-to-one frame-locked arbiter. A grant locks on the first beat and
// is released by a beat whose release bit is set. Data path is purely
// combinational. m.ready must not depend on m.valid.
// **************************************************************************
`timescale 1ns/1ps
`default_nettype none

module data_m2s_arbiter
    import arb_pkg::*;
#(
    parameter int          NUM       = 4,               // Source count
    parameter arb_policy_e POLICY    = ARB_ROUND_ROBIN, // Grant policy
    parameter type         payload_t = logic [31:0]     // Beat format
)(
    input  wire            aclk,
    input  wire            rst,
    input  wire [NUM-1:0]  frame_release,           // Per source, beat ends frame
    data_if.slave          s [NUM],                 // Upstream channels
    data_if.master         m                        // Merged channel
);

    localparam int IW = idx_w(NUM);                 // Source index width

    payload_t          s_data [NUM];                // Flattened source payloads
    logic [NUM-1:0]    s_valid;                     // Flattened source valids
    logic              locked;                      // Frame in progress
    logic [IW-1:0]     owner;                       // Source holding the lock
    logic [IW-1:0]     rr_ptr;                      // Last owner for round robin
    logic [IW-1:0]     pick;                        // Winner of a fresh search
    logic              found;                       // Any requester this cycle
    logic [IW-1:0]     sel;                         // Source routed to m
    logic              gnt_any;                     // Some source is granted
    logic [NUM-1:0]    grant;                       // One-hot grant
    logic              xfer;                        // Beat moves to m

    // **********************************************************************
    // Source fan-in and ready fan-out
    // **********************************************************************
    for (genvar i = 0; i < NUM; i++) begin : g_src
        assign s_data[i]  = s[i].data;
        assign s_valid[i] = s[i].valid;
        assign s[i].ready = grant[i] && m.ready;    // Only the owner sees ready
    end

    // Search for the next requester
    always_comb begin
        int cand;
        pick  = '0;
        found = 1'b0;
        for (int k = 0; k < NUM; k++) begin
            if (POLICY == ARB_FIXED) begin
                cand = k;                           // Lowest index first
            end else begin
                cand = (int'(rr_ptr) + 1 + k) % NUM; // Start after last owner
            end
            if (!found && s_valid[cand]) begin
                pick  = IW'(cand);
                found = 1'b1;
            end
        end
    end

    assign sel     = locked ? owner : pick;         // Lock overrides search
    assign gnt_any = locked || found;
    assign grant   = gnt_any ? (NUM'(1) << sel) : '0;

    assign m.data  = s_data[sel];
    assign m.valid = gnt_any && s_valid[sel];
    assign xfer    = m.valid && m.ready;

    // **********************************************************************
    // Lock and pointer state
    // **********************************************************************
    always_ff @(posedge aclk) begin
        if (rst) begin
            locked <= 1'b0;
            owner  <= '0;
            rr_ptr <= IW'(NUM - 1);                 // Next search begins at 0
        end else if (xfer) begin
            locked <= !frame_release[sel];          // Release beat frees next cycle
            owner  <= sel;
            rr_ptr <= sel;
        end
    end

    // A free arbiter grants exactly one requesting source
    a_grant_onehot: assert property (@(posedge aclk) disable iff (rst)
        !locked && (s_valid != '0) |-> $onehot(grant & s_valid));

    // Routing stays with the source after a beat that does not end the frame
    a_owner_stable: assert property (@(posedge aclk) disable iff (rst)
        xfer && !frame_release[sel] |=> sel == $past(sel));

    a_valid_hold: assert property (@(posedge aclk) disable iff (rst)
        m.valid && !m.ready |=> m.valid);

endmodule

`default_nettype wire

/* verilog/axis_m2s_bind_tuser.sv */
// **************************************************************************
// Many-to-one AXI-Stream merge. A grant holds until a beat with tlast and
// tuser both set, so tlast alone only closes a sub-frame. Output is
// registered through a two-entry skid stage.
// **************************************************************************
`timescale 1ns/1ps
`default_nettype none

module axis_m2s_bind_tuser
    import axis_pkg::*;
    import arb_pkg::*;
#(
    parameter int          NUM    = 4,              // Source count
    parameter int          DATA_W = DATA_W_DEF,     // tdata width
    parameter arb_policy_e POLICY = ARB_ROUND_ROBIN // Grant policy
)(
    input  wire        aclk,
    input  wire        rst,
    axis_if.slave      s [NUM],                     // Upstream streams
    axis_if.master     m                            // Merged stream
);

    localparam int KEEP_W = keep_w(DATA_W);

    // Beat layout for this data width
    typedef struct packed {
        logic [KEEP_W-1:0] tkeep;
        logic              tuser;
        logic              tlast;
        logic [DATA_W-1:0] tdata;
    } beat_t;

    logic [NUM-1:0] frame_release;                  // tlast with tuser per source

    data_if #(.payload_t(beat_t)) src_dif [NUM] (); // Packed sources
    data_if #(.payload_t(beat_t)) arb_dif ();       // Arbiter to skid
    data_if #(.payload_t(beat_t)) out_dif ();       // Skid to output

    // Pack each source
    for (genvar i = 0; i < NUM; i++) begin : g_pack
        assign src_dif[i].data.tkeep = s[i].tkeep;
        assign src_dif[i].data.tuser = s[i].tuser;
        assign src_dif[i].data.tlast = s[i].tlast;
        assign src_dif[i].data.tdata = s[i].tdata;
        assign src_dif[i].valid      = s[i].tvalid;
        assign s[i].tready           = src_dif[i].ready;
        assign frame_release[i]      = s[i].tlast && s[i].tuser; // Whole frame done
    end

    data_m2s_arbiter #(
        .NUM       (NUM),
        .POLICY    (POLICY),
        .payload_t (beat_t)
    ) arb_i (
        .aclk          (aclk),
        .rst           (rst),
        .frame_release (frame_release),
        .s             (src_dif),
        .m             (arb_dif)
    );

    data_skid_pipe #(
        .payload_t (beat_t)
    ) skid_i (
        .aclk (aclk),
        .rst  (rst),
        .s    (arb_dif),
        .m    (out_dif)
    );

    // Unpack onto the output stream
    assign m.tkeep        = out_dif.data.tkeep;
    assign m.tuser        = out_dif.data.tuser;
    assign m.tlast        = out_dif.data.tlast;
    assign m.tdata        = out_dif.data.tdata;
    assign m.tvalid       = out_dif.valid;
    assign out_dif.ready  = m.tready;

    a_keep_width: assert property (@(posedge aclk)
        $bits(m.tkeep) == keep_w(DATA_W));

endmodule

`default_nettype wire

/* verilog/axis_m2s_top.sv */
// **************************************************************************
// Top level with flattened ports. Source i occupies slice i of every
// s_* vector. Latency is one cycle from source transfer to m_tvalid.
// s_tready stays low during reset and one cycle after.
// **************************************************************************
`timescale 1ns/1ps
`default_nettype none

module axis_m2s_top
    import axis_pkg::*;
    import arb_pkg::*;
#(
    parameter int          NUM    = 4,              // Source count
    parameter int          DATA_W = DATA_W_DEF,     // tdata width
    parameter arb_policy_e POLICY = ARB_ROUND_ROBIN // Grant policy
)(
    input  wire                          aclk,
    input  wire                          rst,
    // Flattened source streams
    input  wire [NUM*DATA_W-1:0]         s_tdata,
    input  wire [NUM*keep_w(DATA_W)-1:0] s_tkeep,
    input  wire [NUM-1:0]                s_tlast,
    input  wire [NUM-1:0]                s_tuser,
    input  wire [NUM-1:0]                s_tvalid,
    output wire [NUM-1:0]                s_tready,
    // Merged stream
    output wire [DATA_W-1:0]             m_tdata,
    output wire [keep_w(DATA_W)-1:0]     m_tkeep,
    output wire                          m_tlast,
    output wire                          m_tuser,
    output wire                          m_tvalid,
    input  wire                          m_tready
);

    localparam int KEEP_W = keep_w(DATA_W);

    axis_if #(.DATA_W(DATA_W)) s_axis [NUM] ();     // One bundle per source
    axis_if #(.DATA_W(DATA_W)) m_axis ();           // Output bundle

    // Slice flat vectors into bundles
    for (genvar i = 0; i < NUM; i++) begin : g_slice
        assign s_axis[i].tdata  = s_tdata[i*DATA_W +: DATA_W];
        assign s_axis[i].tkeep  = s_tkeep[i*KEEP_W +: KEEP_W];
        assign s_axis[i].tlast  = s_tlast[i];
        assign s_axis[i].tuser  = s_tuser[i];
        assign s_axis[i].tvalid = s_tvalid[i];
        assign s_tready[i]      = s_axis[i].tready;
    end

    axis_m2s_bind_tuser #(
        .NUM    (NUM),
        .DATA_W (DATA_W),
        .POLICY (POLICY)
    ) intc_i (
        .aclk (aclk),
        .rst  (rst),
        .s    (s_axis),
        .m    (m_axis)
    );

    assign m_tdata         = m_axis.tdata;
    assign m_tkeep         = m_axis.tkeep;
    assign m_tlast         = m_axis.tlast;
    assign m_tuser         = m_axis.tuser;
    assign m_tvalid        = m_axis.tvalid;
    assign m_axis.tready   = m_tready;

endmodule

`default_nettype wire

/* tests/tb_axis_m2s.sv */
// **************************************************************************
// Self-checking testbench for the many-to-one AXI-Stream interconnect.
// Built for NUM 4, DATA_W 32 and round robin. Three phases run in turn.
// Full rate from all sources, then random back-pressure with source gaps,
// then source 0 alone at full rate. Outputs are sampled on the falling edge.
// **************************************************************************
`timescale 1ns/1ps
`default_nettype none

module tb_axis_m2s
    import axis_pkg::*;
    import arb_pkg::*;
();

    localparam int NUM         = 4;
    localparam int DATA_W      = 32;
    localparam int KW          = keep_w(DATA_W);
    localparam int IW          = idx_w(NUM);
    localparam int SEQ_W       = DATA_W - IW;           // Sequence field below the index
    localparam int CLK_NS      = 40;
    localparam int DRIVE_DLY   = 5;                     // Input skew after rising edge
    localparam int RST_CYC     = 10;
    localparam int N1          = 16;                    // End of full rate phase
    localparam int N2          = 48;                    // End of back-pressure phase
    localparam int N3          = 64;                    // End of single source phase
    localparam int TOTAL_BEATS = (NUM - 1) * N2 + N3;
    localparam int WATCHDOG_NS = (TOTAL_BEATS * 40 + 200) * CLK_NS;

    logic                  aclk;
    logic                  rst;
    wire  [NUM*DATA_W-1:0] s_tdata;
    wire  [NUM*KW-1:0]     s_tkeep;
    wire  [NUM-1:0]        s_tlast;
    wire  [NUM-1:0]        s_tuser;
    wire  [NUM-1:0]        s_tvalid;
    wire  [NUM-1:0]        s_tready;
    wire  [DATA_W-1:0]     m_tdata;
    wire  [KW-1:0]         m_tkeep;
    wire                   m_tlast;
    wire                   m_tuser;
    wire                   m_tvalid;
    logic                  m_tready;

    logic [KW-1:0] keep_tab [NUM][N3];                  // Queued tkeep per beat
    logic          last_tab [NUM][N3];
    logic          user_tab [NUM][N3];                  // Set only on frame end
    logic          gap_tab  [NUM][N3];                  // Idle cycle before the beat
    int            xfer_cyc [NUM][N3];                  // Cycle of each source transfer
    int            sent     [NUM] = '{default: 0};
    int            next_seq [NUM] = '{default: 0};      // Next expected beat per source
    integer        seed;
    int            phase      = 0;
    int            cyc        = 0;
    int            rx_count   = 0;
    int            frames     = 0;
    int            beat_errs  = 0;
    int            src_errs   = 0;
    int            ctl_errs   = 0;
    int            other_errs = 0;

    axis_m2s_top #(
        .NUM    (NUM),
        .DATA_W (DATA_W),
        .POLICY (ARB_ROUND_ROBIN)
    ) dut_i (
        .aclk     (aclk),
        .rst      (rst),
        .s_tdata  (s_tdata),
        .s_tkeep  (s_tkeep),
        .s_tlast  (s_tlast),
        .s_tuser  (s_tuser),
        .s_tvalid (s_tvalid),
        .s_tready (s_tready),
        .m_tdata  (m_tdata),
        .m_tkeep  (m_tkeep),
        .m_tlast  (m_tlast),
        .m_tuser  (m_tuser),
        .m_tvalid (m_tvalid),
        .m_tready (m_tready)
    );

    // **********************************************************************
    // Reference model and compare tasks
    // **********************************************************************
    function automatic int beats_for(input int src);
        return (src == 0) ? N3 : N2;                    // Only source 0 runs phase 3
    endfunction

    // Beat number seq of source src, index in the top bits of tdata
    function automatic axis_beat_t expected_beat(input int src, input int seq);
        axis_beat_t b;
        b.tdata = {IW'(src), SEQ_W'(seq)};
        b.tkeep = keep_tab[src][seq];
        b.tlast = last_tab[src][seq];
        b.tuser = user_tab[src][seq];
        return b;
    endfunction

    task automatic check_beat(input axis_beat_t got, input axis_beat_t exp);
        if (got.tdata !== exp.tdata) begin
            beat_errs++;
            $display("ERROR %0t m_tdata got %h expected %h", $time, got.tdata, exp.tdata);
        end
        if (got.tkeep !== exp.tkeep) begin
            beat_errs++;
            $display("ERROR %0t m_tkeep got %h expected %h", $time, got.tkeep, exp.tkeep);
        end
        if (got.tlast !== exp.tlast) begin
            beat_errs++;
            $display("ERROR %0t m_tlast got %b expected %b", $time, got.tlast, exp.tlast);
        end
        if (got.tuser !== exp.tuser) begin
            beat_errs++;
            $display("ERROR %0t m_tuser got %b expected %b", $time, got.tuser, exp.tuser);
        end
    endtask

    task automatic check_src(input string name, input logic [IW-1:0] got,
                             input logic [IW-1:0] exp);
        if (got !== exp) begin
            src_errs++;
            $display("ERROR %0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            ctl_errs++;
            $display("ERROR %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_latency(input int got, input int exp);
        if (got != exp) begin
            ctl_errs++;
            $display("ERROR %0t m_tvalid latency got %0d expected %0d", $time, got, exp);
        end
    endtask

    // **********************************************************************
    // Clock, cycle count, output ready and watchdog
    // **********************************************************************
    initial begin : clock_gen
        aclk = 1'b0;
        forever #(CLK_NS / 2) aclk = ~aclk;
    end

    always @(posedge aclk) cyc <= cyc + 1;

    initial begin : ready_drive
        m_tready = 1'b0;
        forever begin
            @(posedge aclk);
            #DRIVE_DLY;
            m_tready = (phase == 2) ? 1'($random(seed) & 1) : 1'b1; // Toggle in phase 2
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Watchdog stopped the run with %0d of %0d beats received",
                 rx_count, TOTAL_BEATS);
        $display("Errors found");
        $finish;
    end

    // **********************************************************************
    // One stimulus process per source
    // **********************************************************************
    for (genvar g = 0; g < NUM; g++) begin : g_src
        logic [DATA_W-1:0] td;
        logic [KW-1:0]     tk;
        logic              tl;
        logic              tu;
        logic              tv;

        assign s_tdata[g*DATA_W +: DATA_W] = td;
        assign s_tkeep[g*KW +: KW]         = tk;
        assign s_tlast[g]                  = tl;
        assign s_tuser[g]                  = tu;
        assign s_tvalid[g]                 = tv;

        initial begin
            int seq;
            seq = 0;
            td  = '0;
            tk  = '0;
            tl  = 1'b0;
            tu  = 1'b0;
            tv  = 1'b0;
            wait (phase == 1);
            while (seq < beats_for(g)) begin
                @(posedge aclk);
                #DRIVE_DLY;
                if (seq == N1 || seq == N2) begin
                    tv = 1'b0;                          // Idle until the next phase
                    wait (phase == ((seq == N1) ? 2 : 3));
                    @(posedge aclk);
                    #DRIVE_DLY;
                end
                if (gap_tab[g][seq]) begin
                    tv = 1'b0;
                    @(posedge aclk);
                    #DRIVE_DLY;
                end
                {tk, tu, tl, td} = expected_beat(g, seq);
                tv = 1'b1;
                do begin
                    @(negedge aclk);
                end while (!s_tready[g]);               // Transfer on the coming edge
                seq++;
            end
            @(posedge aclk);
            #DRIVE_DLY;
            tv = 1'b0;
        end
    end

    // **********************************************************************
    // Output monitor
    // **********************************************************************
    initial begin : monitor
        axis_beat_t    got;
        axis_beat_t    prev;
        logic          stalled;
        logic          rst_q;
        logic          locked;
        logic [IW-1:0] src;
        logic [IW-1:0] owner;
        int            q;
        stalled = 1'b0;
        rst_q   = 1'b1;
        locked  = 1'b0;
        owner   = '0;
        @(posedge aclk);                                // First reset edge applied
        forever begin
            @(negedge aclk);
            got = {m_tkeep, m_tuser, m_tlast, m_tdata};
            if (rst || rst_q) begin
                check_bit("m_tvalid", m_tvalid, 1'b0); // Also first cycle after reset
            end
            for (int i = 0; i < NUM; i++) begin
                if (rst) begin
                    check_bit($sformatf("s_tready[%0d]", i), s_tready[i], 1'b0);
                end else if (s_tvalid[i] && s_tready[i] && sent[i] < beats_for(i)) begin
                    xfer_cyc[i][sent[i]] = cyc;
                    sent[i]++;
                end
            end
            if (stalled) begin
                check_bit("m_tvalid", m_tvalid, 1'b1); // Held under back-pressure
                check_beat(got, prev);
            end
            if (m_tvalid && m_tready) begin
                src = got.tdata[DATA_W-1 -: IW];
                q   = next_seq[src];
                if (locked) begin
                    check_src("frame owner", src, owner);
                end else begin
                    if (phase == 1 && frames < 5) begin
                        check_src("round robin owner", src, IW'(frames % NUM));
                    end
                    frames++;
                    owner = src;
                end
                if (q >= beats_for(src)) begin
                    other_errs++;
                    $display("Source %0d delivered an extra beat at %0t", src, $time);
                end else begin
                    check_beat(got, expected_beat(src, q));
                    if (phase != 2) begin
                        check_latency(cyc - xfer_cyc[src][q], 1);
                    end
                    next_seq[src] = q + 1;
                end
                locked = !(got.tlast && got.tuser);     // Frame ends on tlast with tuser
                rx_count++;
            end
            stalled = m_tvalid && !m_tready;
            prev    = got;
            rst_q   = rst;
        end
    end

    // **********************************************************************
    // Tables, reset and phase sequence
    // **********************************************************************
    initial begin : main
        logic fin;
        int   errs;
        seed = 32'hec84;
        rst  = 1'b1;
        for (int s = 0; s < NUM; s++) begin
            for (int q = 0; q < N3; q++) begin
                fin            = (q % 8 == 7) || (($random(seed) & 7) == 0);
                keep_tab[s][q] = KW'($random(seed));
                last_tab[s][q] = fin || (($random(seed) & 3) == 0);
                user_tab[s][q] = fin;
                gap_tab[s][q]  = (q >= N1) && (q < N2) && (($random(seed) & 3) == 0);
            end
        end
        repeat (RST_CYC) @(posedge aclk);
        #DRIVE_DLY;
        rst   = 1'b0;
        phase = 1;
        wait (rx_count == NUM * N1);
        phase = 2;                                      // Random back-pressure and gaps
        wait (rx_count == NUM * N2);
        phase = 3;                                      // Source 0 alone at full rate
        wait (rx_count == TOTAL_BEATS);
        repeat (8) @(negedge aclk);
        for (int s = 0; s < NUM; s++) begin
            if (next_seq[s] != beats_for(s) || sent[s] != beats_for(s)) begin
                other_errs++;
                $display("Source %0d sent %0d and delivered %0d of %0d beats",
                         s, sent[s], next_seq[s], beats_for(s));
            end
        end
        errs = beat_errs + src_errs + ctl_errs + other_errs;
        $display("Error counts: beat %0d, source %0d, control %0d, other %0d",
                 beat_errs, src_errs, ctl_errs, other_errs);
        if (errs == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
verilog/axis_pkg.sv
verilog/arb_pkg.sv
verilog/axis_if.sv
verilog/data_if.sv
verilog/data_skid_pipe.sv
verilog/data_m2s_arbiter.sv
verilog/axis_m2s_bind_tuser.sv
verilog/axis_m2s_top.sv
tests/tb_axis_m2s.sv

/* Makefile */
TOP := tb_axis_m2s
OBJ := obj_dir

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f build.f --top-module axis_m2s_top
	verilator --lint-only --timing -f build.f --top-module $(TOP)

sim:
	verilator --binary --timing -f build.f --top-module $(TOP) -Mdir $(OBJ)
	@out="$$(./$(OBJ)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'No errors'

clean:
	rm -rf $(OBJ)
